/* Bender.yml */
package:
  name: mem_subsys

sources:
  - files:
      - logic/sram_pkg.sv
      - logic/byte_ram.sv
      - logic/sram.sv
      - logic/boot_packer.sv
      - logic/boot_counter.sv
      - logic/boot_ctrl.sv
      - logic/mem_subsys_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_mem_subsys.sv

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// failure counts per check kind
int err_data   = 0;
int err_flags  = 0;
int err_booted = 0;

// read data against the shadow memory
task automatic check_word(input string name, input bus_word_u exp, input bus_word_u act);
   if (act.word !== exp.word) begin
      err_data++;
      $display("error %s expected %h actual %h", name, exp.word, act.word);
   end
endtask

// rvalid and ready only, rdata goes through check_word
task automatic check_rsp(input string name, input iob_rsp_t exp, input iob_rsp_t act);
   if (act.rvalid !== exp.rvalid || act.ready !== exp.ready) begin
      err_flags++;
      $display("error %s expected rvalid=%b ready=%b actual rvalid=%b ready=%b",
               name, exp.rvalid, exp.ready, act.rvalid, act.ready);
   end
endtask

task automatic check_booted(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      err_booted++;
      $display("error %s expected %b actual %b", name, exp, act);
   end
endtask

function automatic int total_errors();
   return err_data + err_flags + err_booted;
endfunction

`endif

/* bench/tb_mem_subsys.sv */
module tb_mem_subsys
   import sram_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   `include "tb_checks.svh"

   // one outstanding read
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      bus_word_u         data;
      int unsigned       due;   // negedge count when rvalid must show
   } exp_t;

   logic                  clk_i = 1'b0;
   logic                  rst_i;
   iob_req_t              ibus_req_i;
   iob_req_t              dbus_req_i;
   iob_rsp_t              ibus_rsp_o;
   iob_rsp_t              dbus_rsp_o;
   logic                  boot_start_i;
   logic [BOOT_CNT_W-1:0] boot_words_i;
   logic [7:0]            boot_byte_i;
   logic                  boot_byte_valid_i;
   logic                  booted_o;

   bus_word_u   shadow [2**ADDR_W];
   exp_t        iq [$];
   exp_t        dq [$];
   int unsigned cyc      = 0;
   int unsigned open_due = 32'h3fff_ffff;  // far away until the boot stream ends
   logic        checking = 1'b0;
   int unsigned nwords;

   mem_subsys_top dut (.*);

   always #5 clk_i = ~clk_i;

   // byte-lane merge of a write into the old word
   function automatic bus_word_u merge_word(bus_word_u old, bus_word_u wdata,
                                            logic [STRB_W-1:0] strb);
      bus_word_u res;
      res = old;
      for (int l = 0; l < STRB_W; l++) begin
         if (strb[l])
            res.bytes[l] = wdata.bytes[l];
      end
      return res;
   endfunction

   function automatic iob_req_t make_req(int unsigned addr, bus_word_u wdata,
                                         logic [STRB_W-1:0] strb);
      iob_req_t r;
      r.avalid = 1'b1;
      r.addr   = ADDR_W'(addr);
      r.wdata  = wdata;
      r.wstrb  = strb;  // zero for a read
      return r;
   endfunction

   task automatic abort_run(input string why);
      $display("timeout: %s", why);
      $display("errors: data %0d, flags %0d, booted %0d", err_data, err_flags, err_booted);
      $display("Simulation finished: FAIL");
      $finish;
   endtask

   // one cycle of requests on both buses
   task automatic drive_requests(input iob_req_t ireq, input iob_req_t dreq);
      exp_t e;
      @(posedge clk_i);
      ibus_req_i <= ireq;
      dbus_req_i <= dreq;
      if (ireq.avalid && ireq.wstrb == '0 && cyc + 1 >= open_due) begin
         e.addr = ireq.addr;
         e.data = shadow[ireq.addr];
         e.due  = cyc + 2;
         iq.push_back(e);
      end
      if (dreq.avalid && dreq.wstrb == '0) begin
         e.addr = dreq.addr;
         e.data = shadow[dreq.addr];
         e.due  = cyc + 2;
         dq.push_back(e);
      end
      // reads above still see the old word
      if (ireq.avalid && ireq.wstrb != '0 && cyc + 1 >= open_due)
         shadow[ireq.addr] = merge_word(shadow[ireq.addr], ireq.wdata, ireq.wstrb);
      if (dreq.avalid && dreq.wstrb != '0)
         shadow[dreq.addr] = merge_word(shadow[dreq.addr], dreq.wdata, dreq.wstrb);
   endtask

   task automatic drive_boot(input int unsigned n);
      bus_word_u w;
      @(posedge clk_i);
      boot_start_i <= 1'b1;
      boot_words_i <= BOOT_CNT_W'(n);
      for (int i = 0; i < n; i++) begin
         for (int k = 0; k < STRB_W; k++) begin
            if ($urandom_range(3, 0) == 0) begin  // idle gap
               @(posedge clk_i);
               boot_start_i      <= 1'b0;
               boot_byte_valid_i <= 1'b0;
            end
            w.bytes[k] = 8'($urandom);
            @(posedge clk_i);
            boot_start_i      <= (i == n / 2 && k == 0);  // restart inside LOAD
            boot_words_i      <= BOOT_CNT_W'(3);
            boot_byte_i       <= w.bytes[k];
            boot_byte_valid_i <= 1'b1;
         end
         shadow[i] = w;
      end
      open_due = cyc + 3;  // word write and then RUN
      @(posedge clk_i);
      boot_start_i      <= 1'b0;
      boot_byte_valid_i <= 1'b0;
   endtask

   task automatic wait_booted();
      int waited;
      waited = 0;
      while (booted_o !== 1'b1) begin
         @(negedge clk_i);
         waited++;
         if (waited > 50)
            abort_run("booted_o never rose after the boot stream");
      end
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while (iq.size() != 0 || dq.size() != 0) begin
         @(negedge clk_i);
         waited++;
         if (waited > 20)
            abort_run("read responses still outstanding at the end");
      end
   endtask

   // compare on the falling edge
   always @(negedge clk_i) begin
      iob_rsp_t exp;
      exp_t     e;
      cyc++;
      if (checking) begin
         exp        = '0;
         exp.ready  = (cyc >= open_due);
         exp.rvalid = (iq.size() > 0) && (iq[0].due == cyc);
         check_rsp("ibus response", exp, ibus_rsp_o);
         if (exp.rvalid) begin
            e = iq.pop_front();
            check_word($sformatf("ibus read %0d", e.addr), e.data, ibus_rsp_o.rdata);
         end
         exp.ready  = 1'b1;
         exp.rvalid = (dq.size() > 0) && (dq[0].due == cyc);
         check_rsp("dbus response", exp, dbus_rsp_o);
         if (exp.rvalid) begin
            e = dq.pop_front();
            check_word($sformatf("dbus read %0d", e.addr), e.data, dbus_rsp_o.rdata);
         end
         check_booted("booted", cyc >= open_due, booted_o);
      end
   end

   initial begin
      int unsigned a;
      int unsigned b;
      bus_word_u   d;
      void'($urandom(97));
      rst_i             = 1'b1;
      ibus_req_i        = '0;
      dbus_req_i        = '0;
      boot_start_i      = 1'b0;
      boot_words_i      = '0;
      boot_byte_i       = '0;
      boot_byte_valid_i = 1'b0;
      repeat (4) @(posedge clk_i);
      rst_i    <= 1'b0;
      checking <= 1'b1;

      drive_requests(make_req(5, '0, '0), '0);  // dropped while the port is closed
      drive_requests('0, '0);

      nwords = $urandom_range(40, 8);
      drive_boot(nwords);
      wait_booted();
      for (int i = 0; i < nwords; i++)
         drive_requests(make_req(i, '0, '0), '0);

      // partial writes each read back
      repeat (24) begin
         a      = $urandom_range(nwords - 1, 0);
         d.word = $urandom;
         drive_requests('0, make_req(a, d, STRB_W'($urandom_range(15, 1))));
         drive_requests('0, make_req(a, '0, '0));
      end

      // reads on both ports every cycle
      repeat (32) begin
         a = $urandom_range(nwords - 1, 0);
         b = (a + 1 + $urandom_range(nwords - 2, 0)) % nwords;
         drive_requests(make_req(a, '0, '0), make_req(b, '0, '0));
      end
      drive_requests('0, '0);

      // boot stream in RUN has no effect
      @(posedge clk_i);
      boot_start_i <= 1'b1;
      boot_words_i <= BOOT_CNT_W'(4);
      repeat (8) begin
         @(posedge clk_i);
         boot_start_i      <= 1'b0;
         boot_byte_i       <= 8'($urandom);
         boot_byte_valid_i <= 1'b1;
      end
      @(posedge clk_i);
      boot_byte_valid_i <= 1'b0;
      for (int i = 0; i < nwords; i++)
         drive_requests(make_req(i, '0, '0), make_req(nwords - 1 - i, '0, '0));
      drive_requests('0, '0);

      wait_drained();
      $display("errors: data %0d, flags %0d, booted %0d", err_data, err_flags, err_booted);
      if (total_errors() == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* compile.f */
+incdir+include
logic/sram_pkg.sv
logic/byte_ram.sv
logic/sram.sv
logic/boot_packer.sv
logic/boot_counter.sv
logic/boot_ctrl.sv
logic/mem_subsys_top.sv
bench/tb_mem_subsys.sv

/* logic/boot_counter.sv */
module boot_counter
   import sram_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  load_i,
   input  logic [BOOT_CNT_W-1:0] count_i,
   input  logic                  step_i,
   output logic [ADDR_W-1:0]     addr_o,
   output logic                  last_o
);

   logic [BOOT_CNT_W-1:0] remain;  // words still to be written

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         remain <= '0;
         addr_o <= '0;
      end else if (load_i) begin
         remain <= count_i;
         addr_o <= '0;  // load starts at word zero
      end else if (step_i) begin
         remain <= remain - 1'b1;
         addr_o <= addr_o + 1'b1;
      end
   end

   assign last_o = step_i && (remain == BOOT_CNT_W'(1));

   a_no_underflow : assert property (
      @(posedge clk_i) disable iff (rst_i)
      step_i |-> remain != '0
   ) else $error("boot_counter: step with no words left");

endmodule

/* logic/boot_ctrl.sv */
module boot_ctrl
   import sram_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  start_i,
   input  logic [BOOT_CNT_W-1:0] count_i,
   input  logic [7:0]            byte_i,
   input  logic                  byte_valid_i,
   input  iob_req_t              cpu_ireq_i,
   output iob_req_t              ireq_o,
   output logic                  ibus_open_o,
   output logic                  booted_o
);

   boot_state_e       state;
   boot_state_e       state_nxt;
   logic              start_ok;
   logic              pk_valid;
   logic              word_wr;
   logic              step;
   logic              last;
   logic [ADDR_W-1:0] wr_addr;
   bus_word_u         word;

   assign start_ok = start_i && (state == IDLE) && (count_i != '0);  // ignored elsewhere
   assign pk_valid = byte_valid_i && (state == LOAD);
   assign step     = word_wr && (state == LOAD);

   boot_packer u_packer (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .byte_i       (byte_i),
      .byte_valid_i (pk_valid),
      .clear_i      (start_ok),
      .word_o       (word),
      .word_wr_o    (word_wr)
   );

   boot_counter u_counter (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .load_i  (start_ok),
      .count_i (count_i),
      .step_i  (step),
      .addr_o  (wr_addr),
      .last_o  (last)
   );

   always_ff @(posedge clk_i) begin
      if (rst_i)
         state <= IDLE;
      else
         state <= state_nxt;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:    if (start_ok) state_nxt = LOAD;
         LOAD:    if (last) state_nxt = RUN;
         RUN:     state_nxt = RUN;  // only reset leaves
         default: state_nxt = IDLE;
      endcase
   end

   // instruction port owner
   always_comb begin
      ireq_o = '0;  // processor masked before boot
      case (state)
         LOAD: begin
            ireq_o.avalid = word_wr;
            ireq_o.addr   = wr_addr;
            ireq_o.wdata  = word;
            ireq_o.wstrb  = '1;  // whole word
         end
         RUN:     ireq_o = cpu_ireq_i;
         default: ireq_o = '0;
      endcase
   end

   assign ibus_open_o = (state == RUN);
   assign booted_o    = (state == RUN);

   a_wr_in_load : assert property (
      @(posedge clk_i) disable iff (rst_i)
      word_wr |-> state == LOAD
   ) else $error("boot_ctrl: packer word outside LOAD");

endmodule

/* logic/boot_packer.sv */
module boot_packer
   import sram_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic [7:0] byte_i,
   input  logic       byte_valid_i,
   input  logic       clear_i,
   output bus_word_u  word_o,
   output logic       word_wr_o
);

   logic [1:0] lane;  // next byte lane to fill

   // control
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         lane      <= '0;
         word_wr_o <= 1'b0;
      end else begin
         word_wr_o <= byte_valid_i && !clear_i && (lane == 2'd3);  // word complete
         if (clear_i)
            lane <= '0;
         else if (byte_valid_i)
            lane <= lane + 2'd1;  // wraps after lane 3
      end
   end

   // little endian, first byte lands in lane 0
   always_ff @(posedge clk_i) begin
      if (byte_valid_i)
         word_o.bytes[lane] <= byte_i;
   end

endmodule

/* logic/byte_ram.sv */
module byte_ram
   import sram_pkg::*;
(
   input  logic      clk_i,
   input  iob_req_t  a_req_i,
   input  iob_req_t  b_req_i,
   output bus_word_u a_rdata_o,
   output bus_word_u b_rdata_o
);

   localparam int unsigned DEPTH = 2 ** ADDR_W;
   localparam int unsigned NPORT = 2;

   bus_word_u mem [DEPTH];

   iob_req_t  req   [NPORT];
   bus_word_u rdata [NPORT];

   assign req[0]    = a_req_i;
   assign req[1]    = b_req_i;
   assign a_rdata_o = rdata[0];
   assign b_rdata_o = rdata[1];

   // read-first on both ports
   // same-address writes from both ports in one cycle are undefined
   always_ff @(posedge clk_i) begin
      for (int p = 0; p < NPORT; p++) begin
         if (req[p].avalid) begin
            rdata[p] <= mem[req[p].addr];  // old word, nonblocking
            for (int l = 0; l < STRB_W; l++) begin
               if (req[p].wstrb[l])
                  mem[req[p].addr].bytes[l] <= req[p].wdata.bytes[l];
            end
         end
      end
   end

   // a live request must carry a real address on either port
   for (genvar p = 0; p < NPORT; p++) begin : g_chk
      a_addr_known : assert property (
         @(posedge clk_i) req[p].avalid |-> !$isunknown(req[p].addr)
      ) else $error("byte_ram port %0d: unknown address with avalid", p);
   end

endmodule

/* logic/mem_subsys_top.sv */
module mem_subsys_top
   import sram_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  iob_req_t              ibus_req_i,
   input  iob_req_t              dbus_req_i,
   output iob_rsp_t              ibus_rsp_o,
   output iob_rsp_t              dbus_rsp_o,
   input  logic                  boot_start_i,
   input  logic [BOOT_CNT_W-1:0] boot_words_i,
   input  logic [7:0]            boot_byte_i,
   input  logic                  boot_byte_valid_i,
   output logic                  booted_o
);

   iob_req_t ireq;       // instruction request after boot muxing
   logic     ibus_open;

   boot_ctrl u_boot (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (boot_start_i),
      .count_i      (boot_words_i),
      .byte_i       (boot_byte_i),
      .byte_valid_i (boot_byte_valid_i),
      .cpu_ireq_i   (ibus_req_i),
      .ireq_o       (ireq),
      .ibus_open_o  (ibus_open),
      .booted_o     (booted_o)
   );

   sram u_sram (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ibus_req_i  (ireq),
      .dbus_req_i  (dbus_req_i),
      .ibus_rsp_o  (ibus_rsp_o),
      .dbus_rsp_o  (dbus_rsp_o),
      .ibus_open_i (ibus_open)
   );

endmodule

/* logic/sram.sv */
module sram
   import sram_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_i,
   input  iob_req_t ibus_req_i,
   input  iob_req_t dbus_req_i,
   output iob_rsp_t ibus_rsp_o,
   output iob_rsp_t dbus_rsp_o,
   input  logic     ibus_open_i
);

   bus_word_u i_rdata;
   bus_word_u d_rdata;
   logic      i_rvalid;
   logic      d_rvalid;

   // port a on the data side, port b on the instruction side
   byte_ram u_ram (
      .clk_i     (clk_i),
      .a_req_i   (dbus_req_i),
      .b_req_i   (ibus_req_i),
      .a_rdata_o (d_rdata),
      .b_rdata_o (i_rdata)
   );

   // read valid one cycle after a request with no strobes
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         i_rvalid <= 1'b0;
         d_rvalid <= 1'b0;
      end else begin
         i_rvalid <= ibus_req_i.avalid & ~(|ibus_req_i.wstrb);
         d_rvalid <= dbus_req_i.avalid & ~(|dbus_req_i.wstrb);
      end
   end

   assign ibus_rsp_o.rdata  = i_rdata;
   assign ibus_rsp_o.rvalid = i_rvalid;
   assign ibus_rsp_o.ready  = ibus_open_i;  // closed until boot is done

   assign dbus_rsp_o.rdata  = d_rdata;
   assign dbus_rsp_o.rvalid = d_rvalid;
   assign dbus_rsp_o.ready  = 1'b1;         // requests may come every cycle

   // while closed, only boot writes reach the instruction port
   // they always carry all four lanes
   a_ibus_closed : assert property (
      @(posedge clk_i) disable iff (rst_i)
      ibus_req_i.avalid && !ibus_open_i |-> ibus_req_i.wstrb == '1
   ) else $error("sram: processor request on ibus before boot finished");

endmodule

/* logic/sram_pkg.sv */
package sram_pkg;

   localparam int unsigned DATA_W     = 32;
   localparam int unsigned STRB_W     = DATA_W / 8;
   localparam int unsigned ADDR_W     = 10;          // word address, 1024 words
   localparam int unsigned BOOT_CNT_W = ADDR_W + 1;  // room for a full memory load

   // one bus word, seen whole or lane by lane
   typedef union packed {
      logic [DATA_W-1:0]         word;
      logic [STRB_W-1:0][7:0]    bytes;  // bytes[0] is the low lane
   } bus_word_u;

   // native bus request
   typedef struct packed {
      logic              avalid;
      logic [ADDR_W-1:0] addr;
      bus_word_u         wdata;
      logic [STRB_W-1:0] wstrb;  // zero means read
   } iob_req_t;

   // native bus response
   typedef struct packed {
      bus_word_u rdata;
      logic      rvalid;  // one cycle after a read request
      logic      ready;
   } iob_rsp_t;

   // boot sequence
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      LOAD = 2'd1,
      RUN  = 2'd2
   } boot_state_e;

endpackage
